// ==== flist.f ====
design/textvid_pkg.sv
design/spi_cmd_fsm.sv
design/video_timing.sv
design/text_screen.sv
design/osc_pwm.sv
design/textvid_top.sv
bench/tb_textvid.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run tb_textvid with verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_textvid -Mdir obj_dir -f flist.f > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_textvid > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -q "Regression failed" "$SIM_LOG"; then
    exit 1
fi
exit 0

// ==== bench/tb_textvid.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_textvid;
    import textvid_pkg::*;

    localparam int CLK_NS    = 20;
    localparam int RST_CYC   = 8;
    localparam int SPI_HALF  = 6;
    localparam int STB_CYC   = 4;
    localparam int LINE_CYC  = 448 * STB_CYC;
    localparam int FRAME_CYC = 312 * LINE_CYC;
    localparam int XFER_CYC  = 36 * SPI_HALF;
    localparam int MAX_XFERS = 64;
    localparam int WDOG_CYC  = 3 * FRAME_CYC + MAX_XFERS * XFER_CYC + 16 * 256 + 100;
    localparam int NUM_TESTS = 7;
    localparam int MAX_SHOWN = 20;
    // visible window in strobes after the sync rise and in lines
    localparam int ACT_X0    = 128;
    localparam int ACT_X1    = 383;
    localparam int ACT_Y0    = 64;
    localparam int ACT_Y1    = 255;
    localparam logic [5:0] WHITE = 6'h3f;
    localparam logic [5:0] BLUE  = 6'h01;

    logic        fclk;
    logic        rst;
    logic        spics_n;
    logic        spick;
    logic        spido;
    byte_t       flash_d_in;
    logic        spidi;
    logic        clkz_out;
    logic        beep;
    logic [1:0]  vred;
    logic [1:0]  vgrn;
    logic [1:0]  vblu;
    logic        vhsync;
    logic        vvsync;
    logic        vcsync;
    logic [13:0] a;
    logic        rompg0_n;
    logic        dos_n;
    logic        rompg2;
    logic        rompg3;
    logic        rompg4;
    logic        csrom;
    logic        romoe_n;
    logic        romwe_n;
    byte_t       flash_d_out;
    logic        flash_d_oe;
    logic [5:0]  rgb_pins;
    logic        rst_d;

    int   errs [NUM_TESTS];
    int   shown;
    int   tests_run;
    int   tests_failed;
    int   h_cyc;
    int   hs_high;
    int   v_cyc;
    int   vs_high;
    int   line_idx;
    int   pix_frames;
    int   k;
    int   clkz_cyc;
    logic h_seen;
    logic v_seen;
    logic hs_prev;
    logic vs_prev;
    logic hs_rise;
    logic hs_fall;
    logic vs_rise;
    logic vs_fall;
    logic text_ready;
    logic pix_armed;
    logic clkz_prev;
    logic clkz_seen;

    textvid_top UUT (.*);

    assign rgb_pins = {vgrn, vred, vblu};

    initial
    begin
        fclk = 1'b0;
        forever #(CLK_NS / 2) fclk = ~fclk;
    end

    // ------------------------------
    // helpers
    task automatic wait_cycles(input int n);
        begin
            repeat (n) @(posedge fclk);
            #2;
        end
    endtask

    task automatic check_value(input int test, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
        begin
            assert (got === exp)
            else
            begin
                errs[test]++;
                if (shown < MAX_SHOWN)
                    $display("Mismatch %s: got %0h, expected %0h", name, got, exp);
                shown++;
            end
        end
    endtask

    task automatic check_true(input int test, input logic cond, input string what);
        begin
            assert (cond === 1'b1)
            else
            begin
                errs[test]++;
                $display("%s", what);
            end
        end
    endtask

    task automatic finish_test(input int test, input string name);
        begin
            tests_run++;
            if (errs[test] != 0)
                tests_failed++;
            $display("test %s %s (%0d errors)", name,
                     (errs[test] == 0) ? "ok" : "FAIL", errs[test]);
        end
    endtask

    // one command byte with cs high then one data byte with cs low
    task automatic spi_xfer(input byte_t cmd, input byte_t data, output byte_t rd);
        int i;
        begin
            spics_n = 1'b1;
            for (i = 7; i >= 0; i--)
            begin
                spick = 1'b0;
                spido = cmd[i];
                wait_cycles(SPI_HALF);
                spick = 1'b1;
                wait_cycles(SPI_HALF);
            end
            spick = 1'b0;
            wait_cycles(SPI_HALF);
            spics_n = 1'b0;
            wait_cycles(SPI_HALF);
            for (i = 7; i >= 0; i--)
            begin
                spick = 1'b0;
                spido = data[i];
                wait_cycles(SPI_HALF);
                rd[i] = spidi;
                spick = 1'b1;
                wait_cycles(SPI_HALF);
            end
            spick = 1'b0;
            wait_cycles(SPI_HALF);
            spics_n = 1'b1;
            wait_cycles(SPI_HALF);
        end
    endtask

    task automatic send_cmd(input byte_t cmd, input byte_t data);
        byte_t unused;
        begin
            spi_xfer(cmd, data, unused);
        end
    endtask

    // ctrl bits are cs, oe, we from bit 0 up
    task automatic check_ctrl(input byte_t ctrl);
        begin
            send_cmd(CMD_FLASH_CTRL, ctrl);
            wait_cycles(2);
            check_value(4, "csrom", csrom, ctrl[0]);
            check_value(4, "romoe_n", romoe_n, !ctrl[1]);
            check_value(4, "romwe_n", romwe_n, !ctrl[2]);
            check_value(4, "flash_d_oe", flash_d_oe, ctrl[0] && !ctrl[1]);
        end
    endtask

    task automatic count_beep(output int n);
        int i;
        begin
            n = 0;
            for (i = 0; i < 256; i++)
            begin
                wait_cycles(1);
                if (beep)
                    n++;
            end
        end
    endtask

    // ------------------------------
    // reset levels
    always @(posedge fclk)
        rst_d <= rst;

    a_reset_levels: assert property (@(posedge fclk) (rst && rst_d) |->
        (spidi && romwe_n && romoe_n && !csrom && !flash_d_oe && rgb_pins == 6'h00
         && vhsync && vvsync && !vcsync))
    else
    begin
        errs[0]++;
        $display("outputs left their reset levels while reset was held");
    end

    // ------------------------------
    // cpu clock toggles every 4 fclk
    always @(negedge fclk)
    begin
        if (rst)
        begin
            clkz_prev = clkz_out;
            clkz_seen = 1'b0;
            clkz_cyc  = 0;
        end
        else
        begin
            clkz_cyc++;
            if (clkz_out !== clkz_prev)
            begin
                if (clkz_seen)
                    check_value(1, "clkz_out half period", clkz_cyc, 4);
                clkz_seen = 1'b1;
                clkz_cyc  = 0;
            end
            else
                check_true(1, clkz_cyc != 8, "clkz_out stopped toggling");
            clkz_prev = clkz_out;
        end
    end

    // ------------------------------
    // raster monitor sampled mid-cycle
    always @(negedge fclk)
    begin
        if (rst)
        begin
            h_seen     = 1'b0;
            v_seen     = 1'b0;
            pix_armed  = 1'b0;
            hs_prev    = vhsync;
            vs_prev    = vvsync;
            h_cyc      = 0;
            hs_high    = 0;
            v_cyc      = 0;
            vs_high    = 0;
            line_idx   = 0;
            pix_frames = 0;
        end
        else
        begin
            hs_rise = vhsync && !hs_prev;
            hs_fall = !vhsync && hs_prev;
            vs_rise = vvsync && !vs_prev;
            vs_fall = !vvsync && vs_prev;
            hs_prev = vhsync;
            vs_prev = vvsync;

            if (hs_rise)
            begin
                if (h_seen)
                    check_value(1, "vhsync period", h_cyc + 1, LINE_CYC);
                h_seen  = 1'b1;
                h_cyc   = 0;
                hs_high = 0;
            end
            else
                h_cyc++;
            if (vhsync)
                hs_high++;
            if (hs_fall && h_seen)
                check_value(1, "vhsync high time", hs_high, 33 * STB_CYC);

            // frame start at line 0
            if (vs_rise)
            begin
                check_true(1, hs_rise, "vvsync rose away from a line start");
                if (v_seen)
                    check_value(1, "vvsync period", v_cyc + 1, FRAME_CYC);
                if (pix_armed)
                    pix_frames++;
                pix_armed = text_ready;
                v_seen    = 1'b1;
                v_cyc     = 0;
                vs_high   = 0;
                line_idx  = 0;
            end
            else
            begin
                v_cyc++;
                if (hs_rise)
                    line_idx++;
            end
            if (vvsync)
                vs_high++;
            if (vs_fall && v_seen)
                check_value(1, "vvsync high time", vs_high, 3 * LINE_CYC);

            if (v_seen)
            begin
                k = h_cyc / STB_CYC;
                if (k < ACT_X0 || k > ACT_X1 || line_idx < ACT_Y0 || line_idx > ACT_Y1)
                    check_value(2, "rgb in blank", rgb_pins, 6'h00);
                else if (pix_armed)
                begin
                    // glyph 41 fills the top left cell only
                    if (line_idx < ACT_Y0 + 8 && k < ACT_X0 + 8)
                        check_value(3, "rgb text pixel", rgb_pins, WHITE);
                    else
                        check_value(3, "rgb text pixel", rgb_pins, BLUE);
                end
            end
        end
    end

    // ------------------------------
    // watchdog
    initial
    begin
        #(WDOG_CYC * CLK_NS);
        $display("watchdog expired after %0d cycles", WDOG_CYC);
        $display("Regression failed");
        $finish;
    end

    // ------------------------------
    // test sequence
    initial
    begin
        byte_t       rd;
        byte_t       val;
        byte_t       fd;
        flash_addr_t fa;
        font_addr_t  ga;
        int          n;
        int          i;
        int          total;

        void'($urandom(32'hf49c9bff));
        rst          = 1'b1;
        rst_d        = 1'b0;
        spics_n      = 1'b1;
        spick        = 1'b0;
        spido        = 1'b0;
        flash_d_in   = 8'h00;
        text_ready   = 1'b0;
        shown        = 0;
        tests_run    = 0;
        tests_failed = 0;
        wait_cycles(RST_CYC);
        rst = 1'b0;
        finish_test(0, "reset levels");

        fa = flash_addr_t'($urandom);
        fd = byte_t'($urandom);
        send_cmd(CMD_FLASH_LO, fa[7:0]);
        send_cmd(CMD_FLASH_MID, fa[15:8]);
        send_cmd(CMD_FLASH_HI, {5'b0, fa[18:16]});
        send_cmd(CMD_FLASH_DATA, fd);
        check_ctrl(8'h05);
        check_value(4, "a", a, fa[13:0]);
        check_value(4, "rompg0_n", rompg0_n, !fa[14]);
        check_value(4, "dos_n", dos_n, fa[15]);
        check_value(4, "rompg2", rompg2, fa[16]);
        check_value(4, "rompg3", rompg3, fa[17]);
        check_value(4, "rompg4", rompg4, fa[18]);
        check_value(4, "flash_d_out", flash_d_out, fd);
        check_ctrl(8'h03);
        check_ctrl(8'h00);
        finish_test(4, "flash registers");

        flash_d_in = byte_t'($urandom);
        spi_xfer(CMD_FLASH_DATA, 8'h00, rd);
        check_value(5, "spidi byte", rd, flash_d_in);
        spi_xfer(8'h00, 8'h00, rd);
        check_value(5, "spidi byte", rd, 8'hff);
        finish_test(5, "flash read-back");

        for (i = 0; i < 3; i++)
        begin
            if (i == 0)
                val = byte_t'($urandom);
            else if (i == 1)
                val = 8'h00;
            else
                val = 8'hff;
            send_cmd(CMD_COVOX, val);
            wait_cycles(4);
            repeat (4)
            begin
                count_beep(n);
                check_value(6, "beep high count", n, val);
            end
        end
        finish_test(6, "covox");

        // blank glyph 0, solid glyph 41, then code 41 in cell 0
        send_cmd(CMD_FONT_LO, 8'h00);
        send_cmd(CMD_FONT_HI, 8'h00);
        repeat (8) send_cmd(CMD_FONT_DATA, 8'h00);
        ga = {8'h41, 3'd0};
        send_cmd(CMD_FONT_LO, ga[7:0]);
        send_cmd(CMD_FONT_HI, {5'b0, ga[10:8]});
        repeat (8) send_cmd(CMD_FONT_DATA, 8'hff);
        send_cmd(CMD_SCR_LO, 8'h00);
        send_cmd(CMD_SCR_HI, 8'h00);
        send_cmd(CMD_SCR_CHAR, 8'h41);
        text_ready = 1'b1;

        wait (pix_frames >= 1);
        wait_cycles(1);
        finish_test(1, "video timing");
        finish_test(2, "blanking");
        finish_test(3, "text pixels");

        total = 0;
        for (i = 0; i < NUM_TESTS; i++)
            total += errs[i];
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, total);
        if (total == 0 && tests_failed == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/textvid_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module textvid_top (
    input  wire                fclk,
    input  wire                rst,
    input  wire                spics_n,
    input  wire                spick,
    input  wire                spido,
    input  wire textvid_pkg::byte_t flash_d_in,
    output logic               spidi,
    output logic               clkz_out,
    output logic               beep,
    output logic [1:0]         vred,
    output logic [1:0]         vgrn,
    output logic [1:0]         vblu,
    output logic               vhsync,
    output logic               vvsync,
    output logic               vcsync,
    output logic [13:0]        a,
    output logic               rompg0_n,
    output logic               dos_n,
    output logic               rompg2,
    output logic               rompg3,
    output logic               rompg4,
    output logic               csrom,
    output logic               romoe_n,
    output logic               romwe_n,
    output textvid_pkg::byte_t flash_d_out,
    output logic               flash_d_oe
);
    import textvid_pkg::*;

    logic        pix_stb;
    vid_pos_s    pos;
    scr_wr_s     scr_wr;
    logic        scr_wr_valid;
    flash_ctrl_s flash;
    byte_t       covox;
    color_t      rgb;

    spi_cmd_fsm u_spi (
        .fclk, .rst, .spics_n, .spick, .spido, .flash_d_in,
        .spidi, .scr_wr, .scr_wr_valid, .flash, .covox
    );

    osc_pwm u_osc (.fclk, .rst, .covox, .pix_stb, .clkz_out, .beep);

    video_timing u_timing (.fclk, .rst, .pix_stb, .pos);

    text_screen u_screen (
        .fclk, .rst, .pix_stb, .pos, .scr_wr, .scr_wr_valid,
        .rgb, .hsync(vhsync), .vsync(vvsync), .csync_n(vcsync)
    );

    assign {vgrn, vred, vblu} = rgb;

    // ----------------------------
    // boot flash pins
    assign a                                = flash.addr[13:0];
    assign rompg0_n                         = ~flash.addr[14];
    assign {rompg4, rompg3, rompg2, dos_n}  = flash.addr[18:15];
    assign csrom                            = flash.cs;
    assign romoe_n                          = ~flash.oe;
    assign romwe_n                          = ~flash.we;
    assign flash_d_out                      = flash.dout;
    // data bus driven only while the flash is selected and not reading
    assign flash_d_oe                       = flash.cs & ~flash.oe;

endmodule

`default_nettype wire

// ==== design/osc_pwm.sv ====
`timescale 1ns/10ps
`default_nettype none

module osc_pwm (
    input  wire                fclk,
    input  wire                rst,
    input  wire textvid_pkg::byte_t covox,
    output logic               pix_stb,
    output logic               clkz_out,
    output logic               beep
);
    import textvid_pkg::*;

    byte_t osc;

    // ----------------------------
    // free-running divider
    always_ff @(posedge fclk)
    begin
        if (rst)
        begin
            osc     <= '0;
            pix_stb <= 1'b0;
            beep    <= 1'b0;
        end
        else
        begin
            osc     <= osc + 1'b1;
            // one strobe every 4 clocks
            pix_stb <= (osc[1:0] == 2'b11);
            // duty of covox/256
            beep    <= (osc < covox);
        end
    end

    // fclk / 8
    assign clkz_out = osc[2];

endmodule

`default_nettype wire

// ==== design/text_screen.sv ====
`timescale 1ns/10ps
`default_nettype none

module text_screen (
    input  wire                   fclk,
    input  wire                   rst,
    input  wire                   pix_stb,
    input  wire textvid_pkg::vid_pos_s pos,
    input  wire textvid_pkg::scr_wr_s  scr_wr,
    input  wire                   scr_wr_valid,
    output textvid_pkg::color_t   rgb,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  csync_n
);
    import textvid_pkg::*;

    byte_t    scr_ram [0:1023] = '{default: 8'h00};
    byte_t    font_ram [0:2047] = '{default: 8'h00};
    byte_t    char_q;
    vid_pos_s pos_q;
    byte_t    glyph_row;
    logic     glyph_bit;
    logic     blank_q;

    // ----------------------------
    // write port from the spi side
    always_ff @(posedge fclk)
    begin
        if (scr_wr_valid)
        begin
            if (scr_wr.to_font)
                font_ram[scr_wr.addr] <= scr_wr.data;
            else
                scr_ram[scr_wr.addr[9:0]] <= scr_wr.data;
        end
    end

    // ----------------------------
    // stage 1, char code fetch
    always_ff @(posedge fclk)
    begin
        if (pix_stb)
            char_q <= scr_ram[{pos.row, pos.col}];
    end

    always_ff @(posedge fclk)
    begin
        if (rst)
            pos_q <= '{hblank: 1'b1, vblank: 1'b1, hsync: 1'b1, vsync: 1'b1,
                       csync: 1'b1, default: '0};
        else if (pix_stb)
            pos_q <= pos;
    end

    // stage 2, glyph row and pixel pick
    assign glyph_row = font_ram[{char_q, pos_q.gline}];
    // pixel 0 is the leftmost, glyph MSB
    assign glyph_bit = glyph_row[~pos_q.pix];

    always_ff @(posedge fclk)
    begin
        if (rst)
        begin
            rgb     <= '0;
            blank_q <= 1'b1;
            hsync   <= 1'b1;
            vsync   <= 1'b1;
            csync_n <= 1'b0;
        end
        else if (pix_stb)
        begin
            blank_q <= pos_q.hblank | pos_q.vblank;
            if (pos_q.hblank || pos_q.vblank)
                rgb <= '0;
            else
                rgb <= glyph_bit ? FG_COLOR : BG_COLOR;
            // syncs ride the same two stages as the pixels
            hsync   <= pos_q.hsync;
            vsync   <= pos_q.vsync;
            csync_n <= ~pos_q.csync;
        end
    end

    a_blank_black: assert property (@(posedge fclk) disable iff (rst)
        blank_q |-> (rgb == '0));

endmodule

`default_nettype wire

// ==== design/video_timing.sv ====
`timescale 1ns/10ps
`default_nettype none

module video_timing (
    input  wire                   fclk,
    input  wire                   rst,
    input  wire                   pix_stb,
    output textvid_pkg::vid_pos_s pos
);
    import textvid_pkg::*;

    coord_t     hcount;
    coord_t     vcount;
    logic       hblank;
    logic       vblank;
    logic       hsync;
    logic       vsync;
    logic       csync;
    logic [4:0] col;
    logic [2:0] pix;
    logic [4:0] row;
    logic [2:0] gline;

    // ----------------------------
    // horizontal
    always_ff @(posedge fclk)
    begin
        if (rst)
        begin
            hcount <= '0;
            hblank <= 1'b1;
            hsync  <= 1'b1;
            csync  <= 1'b1;
            col    <= '0;
            pix    <= '0;
        end
        else if (pix_stb)
        begin
            if (hcount == HMAX)
                hcount <= '0;
            else
                hcount <= hcount + 1'b1;

            if (hcount == HBLNK_BEG)
                hblank <= 1'b1;
            else if (hcount == HBLNK_END)
                hblank <= 1'b0;

            // csync stays up through the line during vsync, cut before next line
            if (hcount == '0)
            begin
                hsync <= 1'b1;
                csync <= 1'b1;
            end
            else if (hcount == HSYNC_END)
            begin
                hsync <= 1'b0;
                if (!vsync)
                    csync <= 1'b0;
            end
            else if (hcount == CSYNC_CUT)
                csync <= 1'b0;

            if (hcount == HBLNK_END)
            begin
                pix <= '0;
                col <= '0;
            end
            else
            begin
                pix <= pix + 1'b1;
                if (pix == 3'd7)
                    col <= col + 1'b1;
            end
        end
    end

    // ----------------------------
    // vertical, steps with the line start
    always_ff @(posedge fclk)
    begin
        if (rst)
        begin
            vcount <= '0;
            vblank <= 1'b1;
            vsync  <= 1'b1;
            row    <= '0;
            gline  <= '0;
        end
        else if (pix_stb && hcount == '0)
        begin
            if (vcount == VMAX)
                vcount <= '0;
            else
                vcount <= vcount + 1'b1;

            if (vcount == VBLNK_BEG)
                vblank <= 1'b1;
            else if (vcount == VBLNK_END)
                vblank <= 1'b0;

            if (vcount == '0)
                vsync <= 1'b1;
            else if (vcount == VSYNC_END)
                vsync <= 1'b0;

            if (vcount == VBLNK_END)
            begin
                gline <= '0;
                row   <= '0;
            end
            else
            begin
                gline <= gline + 1'b1;
                if (gline == 3'd7)
                    row <= row + 1'b1;
            end
        end
    end

    assign pos = '{hblank: hblank, vblank: vblank, hsync: hsync, vsync: vsync,
                   csync: csync, col: col, row: row, gline: gline, pix: pix};

    a_hcount_range: assert property (@(posedge fclk) disable iff (rst) hcount <= HMAX);

endmodule

`default_nettype wire

// ==== design/spi_cmd_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_cmd_fsm (
    input  wire                      fclk,
    input  wire                      rst,
    input  wire                      spics_n,
    input  wire                      spick,
    input  wire                      spido,
    input  wire textvid_pkg::byte_t  flash_d_in,
    output logic                     spidi,
    output textvid_pkg::scr_wr_s     scr_wr,
    output logic                     scr_wr_valid,
    output textvid_pkg::flash_ctrl_s flash,
    output textvid_pkg::byte_t       covox
);
    import textvid_pkg::*;

    logic [2:0]  cs_sr;
    logic [2:0]  ck_sr;
    logic [1:0]  do_sr;
    logic        cs_rise;
    logic        cs_fall;
    logic        ck_rise;
    logic        ck_fall;
    spi_state_e  state;
    byte_t       cmd_sr;
    byte_t       data_sr;
    byte_t       out_sr;
    scr_addr_t   scr_addr;
    font_addr_t  font_addr;
    logic        scr_inc;
    logic        font_inc;
    flash_addr_t flash_addr;
    byte_t       flash_dout;
    logic        flash_cs;
    logic        flash_oe;
    logic        flash_we;

    // ----------------------------
    // two-flop sync plus one for edges
    always_ff @(posedge fclk)
    begin
        if (rst)
        begin
            cs_sr <= 3'b111;
            ck_sr <= 3'b000;
            do_sr <= 2'b00;
        end
        else
        begin
            cs_sr <= {cs_sr[1:0], spics_n};
            ck_sr <= {ck_sr[1:0], spick};
            do_sr <= {do_sr[0], spido};
        end
    end

    assign cs_rise = cs_sr[1] & ~cs_sr[2];
    assign cs_fall = ~cs_sr[1] & cs_sr[2];
    assign ck_rise = ck_sr[1] & ~ck_sr[2];
    assign ck_fall = ~ck_sr[1] & ck_sr[2];

    always_ff @(posedge fclk)
    begin
        if (rst)
            state <= IDLE_CMD;
        else
        begin
            case (state)
                IDLE_CMD, SHIFT_CMD:
                    if (cs_fall)
                        state <= WAIT_DATA;
                    else if (ck_rise)
                        state <= SHIFT_CMD;
                WAIT_DATA, SHIFT_DATA:
                    if (cs_rise)
                        state <= COMMIT;
                    else if (ck_rise)
                        state <= SHIFT_DATA;
                default:
                    state <= ck_rise ? SHIFT_CMD : IDLE_CMD;
            endcase
        end
    end

    // ----------------------------
    // bit shifters, MSB first both ways
    always_ff @(posedge fclk)
    begin
        if (rst)
        begin
            cmd_sr <= 8'h00;
            out_sr <= 8'hff;
        end
        else
        begin
            if (ck_rise && cs_sr[1])
                cmd_sr <= {cmd_sr[6:0], do_sr[1]};
            if (cs_fall)
                out_sr <= (cmd_sr == CMD_FLASH_DATA) ? flash_d_in : 8'hff;
            else if (ck_fall && !cs_sr[1])
                out_sr <= {out_sr[6:0], 1'b1};
        end
    end

    always_ff @(posedge fclk)
    begin
        if (ck_rise && !cs_sr[1])
            data_sr <= {data_sr[6:0], do_sr[1]};
    end

    assign spidi = out_sr[7];

    // ----------------------------
    // register writes at commit
    always_ff @(posedge fclk)
    begin
        if (rst)
        begin
            flash_cs     <= 1'b0;
            flash_oe     <= 1'b0;
            flash_we     <= 1'b0;
            covox        <= COVOX_RESET;
            scr_addr     <= '0;
            font_addr    <= '0;
            scr_inc      <= 1'b0;
            font_inc     <= 1'b0;
            scr_wr_valid <= 1'b0;
        end
        else
        begin
            scr_wr_valid <= 1'b0;
            // step past the cell or glyph row just written
            if (cs_fall)
            begin
                if (scr_inc)
                    scr_addr <= scr_addr + 1'b1;
                if (font_inc)
                    font_addr <= font_addr + 1'b1;
                scr_inc  <= 1'b0;
                font_inc <= 1'b0;
            end
            if (state == COMMIT)
            begin
                case (cmd_sr)
                    CMD_FLASH_CTRL:
                    begin
                        flash_cs <= data_sr[0];
                        flash_oe <= data_sr[1];
                        flash_we <= data_sr[2];
                    end
                    CMD_SCR_LO:    scr_addr[7:0] <= data_sr;
                    CMD_SCR_HI:    scr_addr[9:8] <= data_sr[1:0];
                    CMD_SCR_FILL:  scr_inc <= 1'b1;
                    CMD_SCR_CHAR:
                    begin
                        scr_wr_valid <= 1'b1;
                        scr_inc      <= 1'b1;
                    end
                    CMD_FONT_LO:   font_addr[7:0] <= data_sr;
                    CMD_FONT_HI:   font_addr[10:8] <= data_sr[2:0];
                    CMD_FONT_DATA:
                    begin
                        scr_wr_valid <= 1'b1;
                        font_inc     <= 1'b1;
                    end
                    CMD_COVOX:     covox <= data_sr;
                    default:       ;
                endcase
            end
        end
    end

    always_ff @(posedge fclk)
    begin
        if (state == COMMIT)
        begin
            scr_wr.to_font <= (cmd_sr == CMD_FONT_DATA);
            scr_wr.addr    <= (cmd_sr == CMD_FONT_DATA) ? font_addr : font_addr_t'(scr_addr);
            scr_wr.data    <= data_sr;
            case (cmd_sr)
                CMD_FLASH_LO:   flash_addr[7:0] <= data_sr;
                CMD_FLASH_MID:  flash_addr[15:8] <= data_sr;
                CMD_FLASH_HI:   flash_addr[18:16] <= data_sr[2:0];
                CMD_FLASH_DATA: flash_dout <= data_sr;
                default:        ;
            endcase
        end
    end

    assign flash = '{addr: flash_addr, dout: flash_dout, cs: flash_cs, oe: flash_oe, we: flash_we};

    // one write per transfer
    a_single_write: assert property (@(posedge fclk) disable iff (rst)
        scr_wr_valid |=> !scr_wr_valid);

    // commit only once chip select is back high
    a_commit_cs_high: assert property (@(posedge fclk) disable iff (rst)
        (state == COMMIT) |-> cs_sr[1]);

endmodule

`default_nettype wire

// ==== design/textvid_pkg.sv ====
`default_nettype none

package textvid_pkg;

    // ----------------------------
    // vector types
    typedef logic [7:0]  byte_t;
    typedef logic [18:0] flash_addr_t;
    typedef logic [9:0]  scr_addr_t;
    typedef logic [10:0] font_addr_t;
    typedef logic [8:0]  coord_t;
    // green, red, blue, two bits each
    typedef logic [5:0]  color_t;

    typedef enum logic [2:0] {
        IDLE_CMD,
        SHIFT_CMD,
        WAIT_DATA,
        SHIFT_DATA,
        COMMIT
    } spi_state_e;

    // ----------------------------
    // bundles between blocks
    typedef struct packed {
        logic       to_font;
        font_addr_t addr;
        byte_t      data;
    } scr_wr_s;

    typedef struct packed {
        flash_addr_t addr;
        byte_t       dout;
        logic        cs;
        logic        oe;
        logic        we;
    } flash_ctrl_s;

    typedef struct packed {
        logic       hblank;
        logic       vblank;
        logic       hsync;
        logic       vsync;
        logic       csync;
        logic [4:0] col;
        logic [4:0] row;
        logic [2:0] gline;
        logic [2:0] pix;
    } vid_pos_s;

    // ----------------------------
    // spi command codes
    localparam byte_t CMD_FLASH_LO   = 8'hf0;
    localparam byte_t CMD_FLASH_MID  = 8'hf1;
    localparam byte_t CMD_FLASH_HI   = 8'hf2;
    localparam byte_t CMD_FLASH_DATA = 8'hf3;
    localparam byte_t CMD_FLASH_CTRL = 8'hf4;
    localparam byte_t CMD_SCR_LO     = 8'h40;
    localparam byte_t CMD_SCR_HI     = 8'h41;
    localparam byte_t CMD_SCR_FILL   = 8'h43;
    localparam byte_t CMD_SCR_CHAR   = 8'h44;
    localparam byte_t CMD_FONT_LO    = 8'h48;
    localparam byte_t CMD_FONT_HI    = 8'h49;
    localparam byte_t CMD_FONT_DATA  = 8'h4a;
    localparam byte_t CMD_COVOX      = 8'hfb;

    // 448 x 312 raster
    localparam coord_t HMAX      = 9'd447;
    localparam coord_t HSYNC_END = 9'd33;
    localparam coord_t HBLNK_END = 9'd128;
    localparam coord_t HBLNK_BEG = 9'd384;
    localparam coord_t CSYNC_CUT = 9'd415;
    localparam coord_t VMAX      = 9'd311;
    localparam coord_t VSYNC_END = 9'd3;
    localparam coord_t VBLNK_END = 9'd64;
    localparam coord_t VBLNK_BEG = 9'd256;

    localparam color_t FG_COLOR    = 6'h3f;
    localparam color_t BG_COLOR    = 6'h01;
    localparam byte_t  COVOX_RESET = 8'h7f;

endpackage

`default_nettype wire
